//--- verilog/alu_dpath_pkg.sv
// Opcode encodings for the shared ALU datapath. XLEN must be even and is 32 by default
`default_nettype none

package alu_dpath_pkg;

  // Default datapath width
  parameter int xlen_default = 32;

  ////////////////////////////////////////
  // Requestor opcodes

  // Regular ALU requestor, one spare code
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_xor, alu_sll, alu_srl, alu_sra, alu_or, alu_and,
    alu_slt, alu_sltu, alu_lui,
    alu_nswapll, alu_nswaphl, alu_nswaplh, alu_nswaphh
  } alu_op_e;

  // Branch requestor
  typedef enum logic [2:0] {
    bjp_cmp_eq, bjp_cmp_ne, bjp_cmp_lt, bjp_cmp_gt, bjp_cmp_ltu, bjp_cmp_gtu,
    bjp_add
  } bjp_op_e;

  // Address requestor
  typedef enum logic [3:0] {
    agu_add, agu_and, agu_or, agu_xor, agu_max, agu_min, agu_maxu, agu_minu,
    agu_swap
  } agu_op_e;

  ////////////////////////////////////////
  // Internal datapath op

  // Zero must stay nop, the mux relies on an AND-OR merge
  typedef enum logic [4:0] {
    dp_nop = 5'd0,
    dp_add, dp_sub, dp_xor, dp_or, dp_and,
    dp_sll, dp_srl, dp_sra, dp_slt, dp_sltu, dp_mvop2,
    dp_max, dp_min, dp_maxu, dp_minu,
    dp_cmp_eq, dp_cmp_ne, dp_cmp_lt, dp_cmp_gt, dp_cmp_ltu, dp_cmp_gtu,
    dp_nswapll, dp_nswaphl, dp_nswaplh, dp_nswaphh
  } dpath_op_e;

endpackage

`default_nettype wire

//--- verilog/alu_req_mux.sv
// Requestor select for the shared ALU. At most one request may be high and this is not checked
`timescale 1ns/100ps
`default_nettype none

module alu_req_mux #(
  parameter int XLEN = 32
) (
  input  logic                       alu_req,
  input  alu_dpath_pkg::alu_op_e     alu_op,
  input  logic [XLEN-1:0]            alu_op1,
  input  logic [XLEN-1:0]            alu_op2,
  input  logic                       bjp_req,
  input  alu_dpath_pkg::bjp_op_e     bjp_op,
  input  logic [XLEN-1:0]            bjp_op1,
  input  logic [XLEN-1:0]            bjp_op2,
  input  logic                       agu_req,
  input  alu_dpath_pkg::agu_op_e     agu_op,
  input  logic [XLEN-1:0]            agu_op1,
  input  logic [XLEN-1:0]            agu_op2,
  output logic [XLEN-1:0]            mux_op1,
  output logic [XLEN-1:0]            mux_op2,
  output alu_dpath_pkg::dpath_op_e   dpath_op
);

  localparam int op_w = $bits(alu_dpath_pkg::dpath_op_e);

  alu_dpath_pkg::dpath_op_e alu_dp;
  alu_dpath_pkg::dpath_op_e bjp_dp;
  alu_dpath_pkg::dpath_op_e agu_dp;

  ////////////////////////////////////////
  // Opcode translation

  always_comb begin
    case (alu_op)
      alu_dpath_pkg::alu_add:     alu_dp = alu_dpath_pkg::dp_add;
      alu_dpath_pkg::alu_sub:     alu_dp = alu_dpath_pkg::dp_sub;
      alu_dpath_pkg::alu_xor:     alu_dp = alu_dpath_pkg::dp_xor;
      alu_dpath_pkg::alu_sll:     alu_dp = alu_dpath_pkg::dp_sll;
      alu_dpath_pkg::alu_srl:     alu_dp = alu_dpath_pkg::dp_srl;
      alu_dpath_pkg::alu_sra:     alu_dp = alu_dpath_pkg::dp_sra;
      alu_dpath_pkg::alu_or:      alu_dp = alu_dpath_pkg::dp_or;
      alu_dpath_pkg::alu_and:     alu_dp = alu_dpath_pkg::dp_and;
      alu_dpath_pkg::alu_slt:     alu_dp = alu_dpath_pkg::dp_slt;
      alu_dpath_pkg::alu_sltu:    alu_dp = alu_dpath_pkg::dp_sltu;
      // LUI just moves the immediate in op2
      alu_dpath_pkg::alu_lui:     alu_dp = alu_dpath_pkg::dp_mvop2;
      alu_dpath_pkg::alu_nswapll: alu_dp = alu_dpath_pkg::dp_nswapll;
      alu_dpath_pkg::alu_nswaphl: alu_dp = alu_dpath_pkg::dp_nswaphl;
      alu_dpath_pkg::alu_nswaplh: alu_dp = alu_dpath_pkg::dp_nswaplh;
      alu_dpath_pkg::alu_nswaphh: alu_dp = alu_dpath_pkg::dp_nswaphh;
      default:                    alu_dp = alu_dpath_pkg::dp_nop;
    endcase
  end

  always_comb begin
    case (bjp_op)
      alu_dpath_pkg::bjp_cmp_eq:  bjp_dp = alu_dpath_pkg::dp_cmp_eq;
      alu_dpath_pkg::bjp_cmp_ne:  bjp_dp = alu_dpath_pkg::dp_cmp_ne;
      alu_dpath_pkg::bjp_cmp_lt:  bjp_dp = alu_dpath_pkg::dp_cmp_lt;
      alu_dpath_pkg::bjp_cmp_gt:  bjp_dp = alu_dpath_pkg::dp_cmp_gt;
      alu_dpath_pkg::bjp_cmp_ltu: bjp_dp = alu_dpath_pkg::dp_cmp_ltu;
      alu_dpath_pkg::bjp_cmp_gtu: bjp_dp = alu_dpath_pkg::dp_cmp_gtu;
      alu_dpath_pkg::bjp_add:     bjp_dp = alu_dpath_pkg::dp_add;
      default:                    bjp_dp = alu_dpath_pkg::dp_nop;
    endcase
  end

  always_comb begin
    case (agu_op)
      alu_dpath_pkg::agu_add:  agu_dp = alu_dpath_pkg::dp_add;
      alu_dpath_pkg::agu_and:  agu_dp = alu_dpath_pkg::dp_and;
      alu_dpath_pkg::agu_or:   agu_dp = alu_dpath_pkg::dp_or;
      alu_dpath_pkg::agu_xor:  agu_dp = alu_dpath_pkg::dp_xor;
      alu_dpath_pkg::agu_max:  agu_dp = alu_dpath_pkg::dp_max;
      alu_dpath_pkg::agu_min:  agu_dp = alu_dpath_pkg::dp_min;
      alu_dpath_pkg::agu_maxu: agu_dp = alu_dpath_pkg::dp_maxu;
      alu_dpath_pkg::agu_minu: agu_dp = alu_dpath_pkg::dp_minu;
      // Swap is a plain move of op2
      alu_dpath_pkg::agu_swap: agu_dp = alu_dpath_pkg::dp_mvop2;
      default:                 agu_dp = alu_dpath_pkg::dp_nop;
    endcase
  end

  ////////////////////////////////////////
  // AND-OR merge of the three requestors

  // No request leaves everything at zero, i.e. nop
  assign mux_op1 = ({XLEN{alu_req}} & alu_op1)
                 | ({XLEN{bjp_req}} & bjp_op1)
                 | ({XLEN{agu_req}} & agu_op1);
  assign mux_op2 = ({XLEN{alu_req}} & alu_op2)
                 | ({XLEN{bjp_req}} & bjp_op2)
                 | ({XLEN{agu_req}} & agu_op2);

  assign dpath_op = alu_dpath_pkg::dpath_op_e'(
                      ({op_w{alu_req}} & alu_dp)
                    | ({op_w{bjp_req}} & bjp_dp)
                    | ({op_w{agu_req}} & agu_dp));

endmodule

`default_nettype wire

//--- verilog/alu_shifter.sv
// Shared shifter of the regular ALU requestor. Shift amount is the low log2(XLEN) bits of op2
`timescale 1ns/100ps
`default_nettype none

module alu_shifter #(
  parameter int XLEN = 32
) (
  input  alu_dpath_pkg::dpath_op_e dpath_op,
  input  logic [XLEN-1:0]          op1,
  input  logic [XLEN-1:0]          op2,
  output logic [XLEN-1:0]          sll_res,
  output logic [XLEN-1:0]          srl_res,
  output logic [XLEN-1:0]          sra_res
);

  localparam int shamt_w = $clog2(XLEN);

  logic                op_right;
  logic                op_shift;
  logic [XLEN-1:0]     shift_in1;
  logic [shamt_w-1:0]  shift_in2;
  logic [XLEN-1:0]     shift_res;
  logic [XLEN-1:0]     eff_mask;

  // Mirror a word end to end
  function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] din);
    logic [XLEN-1:0] dout;
    for (int i = 0; i < XLEN; i++) begin
      dout[i] = din[XLEN-1-i];
    end
    return dout;
  endfunction

  assign op_right = (dpath_op == alu_dpath_pkg::dp_srl) | (dpath_op == alu_dpath_pkg::dp_sra);
  assign op_shift = op_right | (dpath_op == alu_dpath_pkg::dp_sll);

  // Inputs held at zero unless a shift is decoded
  // Right shifts reuse the left shifter on a mirrored operand
  assign shift_in1 = {XLEN{op_shift}} & (op_right ? bit_rev(op1) : op1);
  assign shift_in2 = {shamt_w{op_shift}} & op2[shamt_w-1:0];

  assign shift_res = shift_in1 << shift_in2;

  assign sll_res = shift_res;
  assign srl_res = bit_rev(shift_res);

  // Mask marks the bits kept from srl, the rest take the sign
  assign eff_mask = {XLEN{1'b1}} >> shift_in2;
  assign sra_res  = (srl_res & eff_mask) | ({XLEN{op1[XLEN-1]}} & ~eff_mask);

endmodule

`default_nettype wire

//--- verilog/alu_adder_cmp.sv
// Shared adder, XOR unit and compare logic. Operands are extended to XLEN+1 bits internally
`timescale 1ns/100ps
`default_nettype none

module alu_adder_cmp #(
  parameter int XLEN = 32
) (
  input  alu_dpath_pkg::dpath_op_e dpath_op,
  input  logic [XLEN-1:0]          op1,
  input  logic [XLEN-1:0]          op2,
  output logic [XLEN-1:0]          addsub_res,
  output logic [XLEN-1:0]          xor_res,
  output logic [XLEN-1:0]          slt_res,
  output logic [XLEN-1:0]          maxmin_res,
  output logic                     cmp_res
);

  logic            op_unsigned;
  logic            adder_sub;
  logic            adder_on;
  logic [XLEN:0]   adder_op1;
  logic [XLEN:0]   adder_op2;
  logic [XLEN:0]   adder_in1;
  logic [XLEN:0]   adder_in2;
  logic            adder_cin;
  logic [XLEN:0]   adder_res;
  logic            xor_on;
  logic [XLEN-1:0] xor_in1;
  logic [XLEN-1:0] xor_in2;
  logic            neq;
  logic            op1_lt_op2;
  logic            maxmin_sel_op1;

  ////////////////////////////////////////
  // Adder

  // Unsigned variants zero-extend
  assign op_unsigned = dpath_op inside {alu_dpath_pkg::dp_sltu, alu_dpath_pkg::dp_cmp_ltu,
                                        alu_dpath_pkg::dp_cmp_gtu, alu_dpath_pkg::dp_maxu,
                                        alu_dpath_pkg::dp_minu};

  // Everything that compares goes through a subtract
  assign adder_sub = dpath_op inside {alu_dpath_pkg::dp_sub, alu_dpath_pkg::dp_slt,
                                      alu_dpath_pkg::dp_sltu, alu_dpath_pkg::dp_cmp_eq,
                                      alu_dpath_pkg::dp_cmp_ne, alu_dpath_pkg::dp_cmp_lt,
                                      alu_dpath_pkg::dp_cmp_gt, alu_dpath_pkg::dp_cmp_ltu,
                                      alu_dpath_pkg::dp_cmp_gtu, alu_dpath_pkg::dp_max,
                                      alu_dpath_pkg::dp_min, alu_dpath_pkg::dp_maxu,
                                      alu_dpath_pkg::dp_minu};
  assign adder_on  = adder_sub | (dpath_op == alu_dpath_pkg::dp_add);

  assign adder_op1 = {(~op_unsigned) & op1[XLEN-1], op1};
  assign adder_op2 = {(~op_unsigned) & op2[XLEN-1], op2};

  // Gated inputs keep the adder quiet when unused
  assign adder_in1 = {(XLEN+1){adder_on}} & adder_op1;
  assign adder_in2 = {(XLEN+1){adder_on}} & (adder_sub ? ~adder_op2 : adder_op2);
  assign adder_cin = adder_on & adder_sub;

  // Two's complement subtract as op1 + ~op2 + 1
  assign adder_res = adder_in1 + adder_in2 + {{XLEN{1'b0}}, adder_cin};
  assign addsub_res = adder_res[XLEN-1:0];

  ////////////////////////////////////////
  // XOR unit

  assign xor_on  = dpath_op inside {alu_dpath_pkg::dp_xor, alu_dpath_pkg::dp_cmp_eq,
                                    alu_dpath_pkg::dp_cmp_ne};
  assign xor_in1 = {XLEN{xor_on}} & op1;
  assign xor_in2 = {XLEN{xor_on}} & op2;
  assign xor_res = xor_in1 ^ xor_in2;

  ////////////////////////////////////////
  // Compare, slt and max/min

  // Any differing bit means not equal
  assign neq = |xor_res;
  // Negative difference means op1 below op2
  assign op1_lt_op2 = adder_res[XLEN];

  // gt also holds on equal operands
  always_comb begin
    case (dpath_op)
      alu_dpath_pkg::dp_cmp_eq:  cmp_res = ~neq;
      alu_dpath_pkg::dp_cmp_ne:  cmp_res = neq;
      alu_dpath_pkg::dp_cmp_lt,
      alu_dpath_pkg::dp_cmp_ltu: cmp_res = op1_lt_op2;
      alu_dpath_pkg::dp_cmp_gt,
      alu_dpath_pkg::dp_cmp_gtu: cmp_res = ~op1_lt_op2;
      default:                   cmp_res = 1'b0;
    endcase
  end

  assign slt_res = {{(XLEN-1){1'b0}},
                    (dpath_op inside {alu_dpath_pkg::dp_slt, alu_dpath_pkg::dp_sltu}) & op1_lt_op2};

  // Max keeps op1 when not below and min keeps op1 when below
  assign maxmin_sel_op1 =
      ((dpath_op inside {alu_dpath_pkg::dp_max, alu_dpath_pkg::dp_maxu}) & ~op1_lt_op2)
    | ((dpath_op inside {alu_dpath_pkg::dp_min, alu_dpath_pkg::dp_minu}) &  op1_lt_op2);
  assign maxmin_res = maxmin_sel_op1 ? op1 : op2;

endmodule

`default_nettype wire

//--- verilog/alu_result_sel.sv
// Final result select of the shared ALU. The half-word swaps assume an even XLEN
`timescale 1ns/100ps
`default_nettype none

module alu_result_sel #(
  parameter int XLEN = 32
) (
  input  alu_dpath_pkg::dpath_op_e dpath_op,
  input  logic [XLEN-1:0]          op1,
  input  logic [XLEN-1:0]          op2,
  input  logic [XLEN-1:0]          sll_res,
  input  logic [XLEN-1:0]          srl_res,
  input  logic [XLEN-1:0]          sra_res,
  input  logic [XLEN-1:0]          addsub_res,
  input  logic [XLEN-1:0]          xor_res,
  input  logic [XLEN-1:0]          slt_res,
  input  logic [XLEN-1:0]          maxmin_res,
  output logic [XLEN-1:0]          res
);

  localparam int half = XLEN / 2;

  logic            op_swap;
  logic            op_addsub;
  logic            op_maxmin;
  logic [XLEN-1:0] swap_op1;
  logic [XLEN-1:0] swap_op2;

  ////////////////////////////////////////
  // Op classes

  // Compares also show their difference on res
  assign op_addsub = dpath_op inside {alu_dpath_pkg::dp_add, alu_dpath_pkg::dp_sub,
                                      alu_dpath_pkg::dp_cmp_eq, alu_dpath_pkg::dp_cmp_ne,
                                      alu_dpath_pkg::dp_cmp_lt, alu_dpath_pkg::dp_cmp_gt,
                                      alu_dpath_pkg::dp_cmp_ltu, alu_dpath_pkg::dp_cmp_gtu};
  assign op_maxmin = dpath_op inside {alu_dpath_pkg::dp_max, alu_dpath_pkg::dp_min,
                                      alu_dpath_pkg::dp_maxu, alu_dpath_pkg::dp_minu};
  assign op_swap   = dpath_op inside {alu_dpath_pkg::dp_nswapll, alu_dpath_pkg::dp_nswaphl,
                                      alu_dpath_pkg::dp_nswaplh, alu_dpath_pkg::dp_nswaphh};

  // Swap operands gated like the other units
  assign swap_op1 = {XLEN{op_swap}} & op1;
  assign swap_op2 = {XLEN{op_swap}} & op2;

  ////////////////////////////////////////
  // Gated-OR select

  // op1 half goes high, op2 half goes low
  assign res =
      ({XLEN{dpath_op == alu_dpath_pkg::dp_or}}    & (op1 | op2))
    | ({XLEN{dpath_op == alu_dpath_pkg::dp_and}}   & (op1 & op2))
    | ({XLEN{dpath_op == alu_dpath_pkg::dp_xor}}   & xor_res)
    | ({XLEN{op_addsub}}                           & addsub_res)
    | ({XLEN{dpath_op == alu_dpath_pkg::dp_sll}}   & sll_res)
    | ({XLEN{dpath_op == alu_dpath_pkg::dp_srl}}   & srl_res)
    | ({XLEN{dpath_op == alu_dpath_pkg::dp_sra}}   & sra_res)
    | ({XLEN{dpath_op == alu_dpath_pkg::dp_mvop2}} & op2)
    | slt_res
    | ({XLEN{op_maxmin}}                           & maxmin_res)
    | ({XLEN{dpath_op == alu_dpath_pkg::dp_nswapll}}
         & {swap_op1[half-1:0], swap_op2[half-1:0]})
    | ({XLEN{dpath_op == alu_dpath_pkg::dp_nswaphl}}
         & {swap_op1[XLEN-1:half], swap_op2[half-1:0]})
    | ({XLEN{dpath_op == alu_dpath_pkg::dp_nswaplh}}
         & {swap_op1[half-1:0], swap_op2[XLEN-1:half]})
    | ({XLEN{dpath_op == alu_dpath_pkg::dp_nswaphh}}
         & {swap_op1[XLEN-1:half], swap_op2[XLEN-1:half]});

endmodule

`default_nettype wire

//--- verilog/alu_shared_buf.sv
// Two shared buffer registers of the address requestor. Loads take one clock and reset is synchronous
`timescale 1ns/100ps
`default_nettype none

module alu_shared_buf #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            sbf_0_ena,
  input  logic [XLEN-1:0] sbf_0_nxt,
  input  logic            sbf_1_ena,
  input  logic [XLEN-1:0] sbf_1_nxt,
  output logic [XLEN-1:0] sbf_0_r,
  output logic [XLEN-1:0] sbf_1_r
);

  // Each buffer holds until its own enable
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sbf_0_r <= '0;
      sbf_1_r <= '0;
    end else begin
      if (sbf_0_ena) begin
        sbf_0_r <= sbf_0_nxt;
      end
      if (sbf_1_ena) begin
        sbf_1_r <= sbf_1_nxt;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/alu_dpath_top.sv
// Shared ALU datapath top. Results are combinational and requests must be mutually exclusive
`timescale 1ns/100ps
`default_nettype none

module alu_dpath_top #(
  parameter int XLEN = alu_dpath_pkg::xlen_default
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // Regular ALU requestor
  input  logic                   alu_req,
  input  alu_dpath_pkg::alu_op_e alu_op,
  input  logic [XLEN-1:0]        alu_op1,
  input  logic [XLEN-1:0]        alu_op2,
  // Branch requestor
  input  logic                   bjp_req,
  input  alu_dpath_pkg::bjp_op_e bjp_op,
  input  logic [XLEN-1:0]        bjp_op1,
  input  logic [XLEN-1:0]        bjp_op2,
  // Address requestor and its buffers
  input  logic                   agu_req,
  input  alu_dpath_pkg::agu_op_e agu_op,
  input  logic [XLEN-1:0]        agu_op1,
  input  logic [XLEN-1:0]        agu_op2,
  input  logic                   agu_sbf_0_ena,
  input  logic [XLEN-1:0]        agu_sbf_0_nxt,
  input  logic                   agu_sbf_1_ena,
  input  logic [XLEN-1:0]        agu_sbf_1_nxt,
  // Shared results
  output logic [XLEN-1:0]        res,
  output logic                   cmp_res,
  output logic [XLEN-1:0]        agu_sbf_0_r,
  output logic [XLEN-1:0]        agu_sbf_1_r
);

  logic [XLEN-1:0]          mux_op1;
  logic [XLEN-1:0]          mux_op2;
  alu_dpath_pkg::dpath_op_e dpath_op;
  logic [XLEN-1:0]          sll_res;
  logic [XLEN-1:0]          srl_res;
  logic [XLEN-1:0]          sra_res;
  logic [XLEN-1:0]          addsub_res;
  logic [XLEN-1:0]          xor_res;
  logic [XLEN-1:0]          slt_res;
  logic [XLEN-1:0]          maxmin_res;

  ////////////////////////////////////////
  // Requestor select

  alu_req_mux #(.XLEN(XLEN)) i_alu_req_mux (
    .alu_req  (alu_req),
    .alu_op   (alu_op),
    .alu_op1  (alu_op1),
    .alu_op2  (alu_op2),
    .bjp_req  (bjp_req),
    .bjp_op   (bjp_op),
    .bjp_op1  (bjp_op1),
    .bjp_op2  (bjp_op2),
    .agu_req  (agu_req),
    .agu_op   (agu_op),
    .agu_op1  (agu_op1),
    .agu_op2  (agu_op2),
    .mux_op1  (mux_op1),
    .mux_op2  (mux_op2),
    .dpath_op (dpath_op)
  );

  ////////////////////////////////////////
  // Shared units

  // Only the regular ALU shifts, so its operands feed the shifter directly
  alu_shifter #(.XLEN(XLEN)) i_alu_shifter (
    .dpath_op (dpath_op),
    .op1      (alu_op1),
    .op2      (alu_op2),
    .sll_res  (sll_res),
    .srl_res  (srl_res),
    .sra_res  (sra_res)
  );

  alu_adder_cmp #(.XLEN(XLEN)) i_alu_adder_cmp (
    .dpath_op   (dpath_op),
    .op1        (mux_op1),
    .op2        (mux_op2),
    .addsub_res (addsub_res),
    .xor_res    (xor_res),
    .slt_res    (slt_res),
    .maxmin_res (maxmin_res),
    .cmp_res    (cmp_res)
  );

  alu_result_sel #(.XLEN(XLEN)) i_alu_result_sel (
    .dpath_op   (dpath_op),
    .op1        (mux_op1),
    .op2        (mux_op2),
    .sll_res    (sll_res),
    .srl_res    (srl_res),
    .sra_res    (sra_res),
    .addsub_res (addsub_res),
    .xor_res    (xor_res),
    .slt_res    (slt_res),
    .maxmin_res (maxmin_res),
    .res        (res)
  );

  // Buffers belong to the address requestor only
  alu_shared_buf #(.XLEN(XLEN)) i_alu_shared_buf (
    .clk       (clk),
    .rst_n     (rst_n),
    .sbf_0_ena (agu_sbf_0_ena),
    .sbf_0_nxt (agu_sbf_0_nxt),
    .sbf_1_ena (agu_sbf_1_ena),
    .sbf_1_nxt (agu_sbf_1_nxt),
    .sbf_0_r   (agu_sbf_0_r),
    .sbf_1_r   (agu_sbf_1_r)
  );

endmodule

`default_nettype wire

//--- sim/alu_dpath_chk.sv
// Assertions bound into alu_dpath_top. Sampled on the rising clock, needs a simulator with SVA
`timescale 1ns/100ps
`default_nettype none

module alu_dpath_chk #(
  parameter int XLEN = 32
) (
  input logic            clk,
  input logic            rst_n,
  input logic            alu_req,
  input logic            bjp_req,
  input logic            agu_req,
  input logic [XLEN-1:0] res,
  input logic            cmp_res,
  input logic [XLEN-1:0] agu_sbf_0_r,
  input logic [XLEN-1:0] agu_sbf_1_r
);

  logic idle;

  // No requestor active
  assign idle = ~(alu_req | bjp_req | agu_req);

  ////////////////////////////////////////
  // Idle datapath stays quiet

  idle_res_zero: assert property (@(posedge clk) idle |-> (res == '0))
    else $error("res is not zero while no request is active");

  idle_cmp_zero: assert property (@(posedge clk) idle |-> (cmp_res == 1'b0))
    else $error("cmp_res is set while no request is active");

  ////////////////////////////////////////
  // Buffers clear one cycle after reset

  buf_reset_clear: assert property (@(posedge clk)
      !rst_n |=> ((agu_sbf_0_r == '0) && (agu_sbf_1_r == '0)))
    else $error("shared buffers not cleared one cycle after reset");

endmodule

bind alu_dpath_top alu_dpath_chk #(.XLEN(XLEN)) i_alu_dpath_chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .alu_req     (alu_req),
  .bjp_req     (bjp_req),
  .agu_req     (agu_req),
  .res         (res),
  .cmp_res     (cmp_res),
  .agu_sbf_0_r (agu_sbf_0_r),
  .agu_sbf_1_r (agu_sbf_1_r)
);

`default_nettype wire

//--- sim/alu_dpath_tb.sv
// Random testbench for alu_dpath_top at XLEN 32. Inputs change on the rising edge, checks on the falling
`timescale 1ns/100ps
`default_nettype none

module alu_dpath_tb;

  localparam int n_alu  = 400;
  localparam int n_swap = 100;
  localparam int n_bjp  = 200;
  localparam int n_dir  = 144;
  localparam int n_agu  = 200;
  localparam int n_idle = 200;
  localparam int n_buf  = 150;
  // Every vector takes one clock, plus reset and a margin
  localparam int n_cycles = 4 + n_alu + n_swap + 6 + n_bjp + n_dir + n_agu + n_idle + n_buf + 2;
  localparam int watchdog_ns = (n_cycles + 100) * 100;

  logic clk;
  logic rst_n;
  logic alu_req;
  alu_dpath_pkg::alu_op_e alu_op;
  logic [31:0] alu_op1;
  logic [31:0] alu_op2;
  logic bjp_req;
  alu_dpath_pkg::bjp_op_e bjp_op;
  logic [31:0] bjp_op1;
  logic [31:0] bjp_op2;
  logic agu_req;
  alu_dpath_pkg::agu_op_e agu_op;
  logic [31:0] agu_op1;
  logic [31:0] agu_op2;
  logic agu_sbf_0_ena;
  logic [31:0] agu_sbf_0_nxt;
  logic agu_sbf_1_ena;
  logic [31:0] agu_sbf_1_nxt;
  logic [31:0] res;
  logic cmp_res;
  logic [31:0] agu_sbf_0_r;
  logic [31:0] agu_sbf_1_r;

  integer seed;
  int check_cnt;
  int err_cnt;
  int test_checks;
  int test_errs;

  alu_dpath_top #(.XLEN(32)) i_alu_dpath_top (
    .clk (clk), .rst_n (rst_n),
    .alu_req (alu_req), .alu_op (alu_op), .alu_op1 (alu_op1), .alu_op2 (alu_op2),
    .bjp_req (bjp_req), .bjp_op (bjp_op), .bjp_op1 (bjp_op1), .bjp_op2 (bjp_op2),
    .agu_req (agu_req), .agu_op (agu_op), .agu_op1 (agu_op1), .agu_op2 (agu_op2),
    .agu_sbf_0_ena (agu_sbf_0_ena), .agu_sbf_0_nxt (agu_sbf_0_nxt),
    .agu_sbf_1_ena (agu_sbf_1_ena), .agu_sbf_1_nxt (agu_sbf_1_nxt),
    .res (res), .cmp_res (cmp_res),
    .agu_sbf_0_r (agu_sbf_0_r), .agu_sbf_1_r (agu_sbf_1_r)
  );

  // 100 ns clock
  always #50 clk = ~clk;

  ////////////////////////////////////////
  // Random helpers

  function automatic int unsigned rand_below(input int unsigned n);
    logic [31:0] r;
    r = $random(seed);
    return r % n;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r;
  endfunction

  // Sign and range corners now and then
  function automatic logic [31:0] rand_operand();
    int unsigned pick;
    pick = rand_below(16);
    case (pick)
      0:       return 32'h0000_0000;
      1:       return 32'h8000_0000;
      2:       return 32'h7fff_ffff;
      3:       return 32'hffff_ffff;
      default: return rand_word();
    endcase
  endfunction

  ////////////////////////////////////////
  // Reference model

  function automatic logic [31:0] alu_model(input alu_dpath_pkg::alu_op_e op,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      alu_dpath_pkg::alu_add:     return a + b;
      alu_dpath_pkg::alu_sub:     return a - b;
      alu_dpath_pkg::alu_xor:     return a ^ b;
      alu_dpath_pkg::alu_or:      return a | b;
      alu_dpath_pkg::alu_and:     return a & b;
      alu_dpath_pkg::alu_sll:     return a << sh;
      alu_dpath_pkg::alu_srl:     return a >> sh;
      alu_dpath_pkg::alu_sra:     return $signed(a) >>> sh;
      alu_dpath_pkg::alu_slt:     return {31'b0, $signed(a) < $signed(b)};
      alu_dpath_pkg::alu_sltu:    return {31'b0, a < b};
      alu_dpath_pkg::alu_lui:     return b;
      // First-named half from a on top, second-named half from b below
      alu_dpath_pkg::alu_nswapll: return {a[15:0], b[15:0]};
      alu_dpath_pkg::alu_nswaphl: return {a[31:16], b[15:0]};
      alu_dpath_pkg::alu_nswaplh: return {a[15:0], b[31:16]};
      alu_dpath_pkg::alu_nswaphh: return {a[31:16], b[31:16]};
      default:                    return 32'h0;
    endcase
  endfunction

  // gt holds on equal operands
  function automatic logic bjp_model(input alu_dpath_pkg::bjp_op_e op,
                                     input logic [31:0] a, input logic [31:0] b);
    case (op)
      alu_dpath_pkg::bjp_cmp_eq:  return a == b;
      alu_dpath_pkg::bjp_cmp_ne:  return a != b;
      alu_dpath_pkg::bjp_cmp_lt:  return $signed(a) < $signed(b);
      alu_dpath_pkg::bjp_cmp_gt:  return $signed(a) >= $signed(b);
      alu_dpath_pkg::bjp_cmp_ltu: return a < b;
      alu_dpath_pkg::bjp_cmp_gtu: return a >= b;
      default:                    return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] agu_model(input alu_dpath_pkg::agu_op_e op,
                                             input logic [31:0] a, input logic [31:0] b);
    case (op)
      alu_dpath_pkg::agu_add:  return a + b;
      alu_dpath_pkg::agu_and:  return a & b;
      alu_dpath_pkg::agu_or:   return a | b;
      alu_dpath_pkg::agu_xor:  return a ^ b;
      alu_dpath_pkg::agu_max:  return ($signed(a) >= $signed(b)) ? a : b;
      alu_dpath_pkg::agu_min:  return ($signed(a) < $signed(b)) ? a : b;
      alu_dpath_pkg::agu_maxu: return (a >= b) ? a : b;
      alu_dpath_pkg::agu_minu: return (a < b) ? a : b;
      alu_dpath_pkg::agu_swap: return b;
      default:                 return 32'h0;
    endcase
  endfunction

  ////////////////////////////////////////
  // Drive and check

  // Inactive requestors see random operands, the mux must mask them
  task automatic drive(input logic ar, input logic br, input logic gr,
                       input alu_dpath_pkg::alu_op_e aop, input alu_dpath_pkg::bjp_op_e bop,
                       input alu_dpath_pkg::agu_op_e gop, input logic [31:0] a,
                       input logic [31:0] b);
    alu_req <= ar;
    bjp_req <= br;
    agu_req <= gr;
    alu_op  <= aop;
    bjp_op  <= bop;
    agu_op  <= gop;
    alu_op1 <= ar ? a : rand_word();
    alu_op2 <= ar ? b : rand_word();
    bjp_op1 <= br ? a : rand_word();
    bjp_op2 <= br ? b : rand_word();
    agu_op1 <= gr ? a : rand_word();
    agu_op2 <= gr ? b : rand_word();
  endtask

  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("Fail at %0d ns: %s gave %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("Fail at %0d ns: %s gave %b, expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic run_alu(input alu_dpath_pkg::alu_op_e op, input logic [31:0] a,
                         input logic [31:0] b);
    @(posedge clk);
    drive(1'b1, 1'b0, 1'b0, op, alu_dpath_pkg::bjp_add, alu_dpath_pkg::agu_add, a, b);
    @(negedge clk);
    check_word($sformatf("%s a=%h b=%h", op.name(), a, b), res, alu_model(op, a, b));
  endtask

  task automatic run_bjp(input alu_dpath_pkg::bjp_op_e op, input logic [31:0] a,
                         input logic [31:0] b);
    @(posedge clk);
    drive(1'b0, 1'b1, 1'b0, alu_dpath_pkg::alu_add, op, alu_dpath_pkg::agu_add, a, b);
    @(negedge clk);
    // Only the add has a defined res
    if (op == alu_dpath_pkg::bjp_add) begin
      check_word($sformatf("branch add a=%h b=%h", a, b), res, a + b);
    end else begin
      check_bit($sformatf("%s a=%h b=%h", op.name(), a, b), cmp_res, bjp_model(op, a, b));
    end
  endtask

  task automatic run_agu(input alu_dpath_pkg::agu_op_e op, input logic [31:0] a,
                         input logic [31:0] b);
    @(posedge clk);
    drive(1'b0, 1'b0, 1'b1, alu_dpath_pkg::alu_add, alu_dpath_pkg::bjp_add, op, a, b);
    @(negedge clk);
    check_word($sformatf("%s a=%h b=%h", op.name(), a, b), res, agu_model(op, a, b));
  endtask

  task automatic run_idle();
    @(posedge clk);
    drive(1'b0, 1'b0, 1'b0, alu_dpath_pkg::alu_op_e'(4'(rand_below(15))),
          alu_dpath_pkg::bjp_op_e'(3'(rand_below(7))),
          alu_dpath_pkg::agu_op_e'(4'(rand_below(9))), rand_word(), rand_word());
    @(negedge clk);
    check_word("idle res", res, 32'h0);
    check_bit("idle cmp_res", cmp_res, 1'b0);
  endtask

  task automatic start_test();
    test_checks = check_cnt;
    test_errs   = err_cnt;
  endtask

  task automatic end_test(input string name);
    $display("%s done: %0d checks, %0d errors", name, check_cnt - test_checks,
             err_cnt - test_errs);
  endtask

  ////////////////////////////////////////
  // Shared buffer test

  task automatic test_buffers();
    logic [31:0] exp0;
    logic [31:0] exp1;
    logic [31:0] d0;
    logic [31:0] d1;
    logic e0;
    logic e1;
    logic clr;
    exp0 = 32'h0;
    exp1 = 32'h0;
    @(negedge clk);
    check_word("sbf_0 after reset", agu_sbf_0_r, 32'h0);
    check_word("sbf_1 after reset", agu_sbf_1_r, 32'h0);
    for (int i = 0; i < n_buf; i++) begin
      @(posedge clk);
      e0  = (rand_below(2) == 1);
      e1  = (rand_below(2) == 1);
      d0  = rand_word();
      d1  = rand_word();
      // Second reset half way through
      clr = (i == n_buf / 2);
      rst_n <= ~clr;
      agu_sbf_0_ena <= e0;
      agu_sbf_0_nxt <= d0;
      agu_sbf_1_ena <= e1;
      agu_sbf_1_nxt <= d1;
      @(negedge clk);
      check_word("sbf_0", agu_sbf_0_r, exp0);
      check_word("sbf_1", agu_sbf_1_r, exp1);
      // Values just driven land at the next edge
      if (clr) begin
        exp0 = 32'h0;
        exp1 = 32'h0;
      end else begin
        if (e0) exp0 = d0;
        if (e1) exp1 = d1;
      end
    end
    @(posedge clk);
    rst_n <= 1'b1;
    agu_sbf_0_ena <= 1'b0;
    agu_sbf_1_ena <= 1'b0;
    @(negedge clk);
    check_word("sbf_0 final", agu_sbf_0_r, exp0);
    check_word("sbf_1 final", agu_sbf_1_r, exp1);
  endtask

  ////////////////////////////////////////
  // Main sequence

  initial begin
    logic [31:0] corner [4];
    logic [31:0] a;
    logic [31:0] b;
    seed = 57427;
    check_cnt = 0;
    err_cnt = 0;
    corner = '{32'h0000_0000, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff};
    clk = 1'b0;
    rst_n = 1'b0;
    alu_req = 1'b0;
    alu_op = alu_dpath_pkg::alu_add;
    alu_op1 = 32'h0;
    alu_op2 = 32'h0;
    bjp_req = 1'b0;
    bjp_op = alu_dpath_pkg::bjp_add;
    bjp_op1 = 32'h0;
    bjp_op2 = 32'h0;
    agu_req = 1'b0;
    agu_op = alu_dpath_pkg::agu_add;
    agu_op1 = 32'h0;
    agu_op2 = 32'h0;
    agu_sbf_0_ena = 1'b0;
    agu_sbf_0_nxt = 32'h0;
    agu_sbf_1_ena = 1'b0;
    agu_sbf_1_nxt = 32'h0;
    // Four clocks of reset
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    start_test();
    for (int i = 0; i < n_alu; i++) begin
      run_alu(alu_dpath_pkg::alu_op_e'(4'(rand_below(11))), rand_operand(), rand_operand());
    end
    end_test("Test 1 regular ALU ops");

    start_test();
    for (int i = 0; i < n_swap; i++) begin
      run_alu(alu_dpath_pkg::alu_op_e'(4'(11 + rand_below(4))), rand_word(), rand_word());
    end
    end_test("Test 2 half-word swaps");

    start_test();
    // Equal operands for every compare first
    for (int k = 0; k < 6; k++) begin
      a = rand_operand();
      run_bjp(alu_dpath_pkg::bjp_op_e'(3'(k)), a, a);
    end
    for (int i = 0; i < n_bjp; i++) begin
      a = rand_operand();
      b = (i % 4 == 0) ? a : rand_operand();
      run_bjp(alu_dpath_pkg::bjp_op_e'(3'(rand_below(7))), a, b);
    end
    end_test("Test 3 branch compares");

    start_test();
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        for (int k = 0; k < 9; k++) begin
          run_agu(alu_dpath_pkg::agu_op_e'(4'(k)), corner[i], corner[j]);
        end
      end
    end
    for (int i = 0; i < n_agu; i++) begin
      run_agu(alu_dpath_pkg::agu_op_e'(4'(rand_below(9))), rand_operand(), rand_operand());
    end
    end_test("Test 4 address ops");

    start_test();
    for (int i = 0; i < n_idle; i++) begin
      if (rand_below(3) == 0) begin
        run_alu(alu_dpath_pkg::alu_op_e'(4'(rand_below(15))), rand_word(), rand_word());
      end else begin
        run_idle();
      end
    end
    end_test("Test 5 idle cycles");

    start_test();
    test_buffers();
    end_test("Test 6 shared buffers");

    $display("Summary: %0d checks passed, %0d checks failed", check_cnt - err_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog sized from the vector counts
  initial begin
    #(watchdog_ns);
    $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
verilog/alu_dpath_pkg.sv
verilog/alu_req_mux.sv
verilog/alu_shifter.sv
verilog/alu_adder_cmp.sv
verilog/alu_result_sel.sv
verilog/alu_shared_buf.sv
verilog/alu_dpath_top.sv
sim/alu_dpath_chk.sv
sim/alu_dpath_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the shared ALU datapath testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module alu_dpath_tb -Mdir "$OBJ" -f build.f
if [ $? -ne 0 ]; then
  echo "Verilator build returned an error"
  exit 1
fi

"./$OBJ/Valu_dpath_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  echo "Failure reported in $LOG"
  exit 1
fi
echo "No failure reported in $LOG"
exit 0
